//--- bench/flags_tb.sv
`default_nettype none

module flags_tb import flag_pkg::*; ();

	// One trace line, stimulus then expected outputs
	typedef struct packed {
		logic        rnd;
		alu_req_t    req;
		bus_load_t   bus;
		logic        cond_en;
		logic [3:0]  cond;
		logic [0:15] exp_result;
		logic [0:15] exp_r0;
		logic        exp_tv;
		logic        exp_taken;
	} trace_row_t;

	localparam string TRACE_PATH = "bench/flags_trace.txt";
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	// Spare cycles on top of trace and reset before the watchdog fires
	localparam int SLACK_CYCLES = 10;

	logic        lrp;
	logic        zer_;
	alu_req_t    req;
	bus_load_t   bus;
	logic        cond_en;
	logic [3:0]  cond;
	logic [0:15] result;
	logic [0:15] r0;
	logic        taken;
	logic        taken_valid;

	// Parsed trace and the file line each entry came from
	trace_row_t rows[$];
	int         row_src_line[$];
	bit         loaded;
	int         checks;
	int         err_result;
	int         err_r0;
	int         err_valid;
	int         err_taken;

	flags_top u_dut (
		.lrp         (lrp),
		.zer_        (zer_),
		.req         (req),
		.bus         (bus),
		.cond_en     (cond_en),
		.cond        (cond),
		.result      (result),
		.r0          (r0),
		.taken       (taken),
		.taken_valid (taken_valid)
	);

	initial begin
		lrp = 1'b0;
		forever #(CLK_PERIOD / 2) lrp = ~lrp;
	end

	// Read every data line of the trace into rows
	task automatic load_trace(output bit ok);
		int          fd;
		int          line_no;
		int          n;
		string       line;
		logic [31:0] col [0:15];
		trace_row_t  row;
		ok = 1'b0;
		line_no = 0;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			$display("Trace file %s is missing or cannot be opened", TRACE_PATH);
			return;
		end
		while ($fgets(line, fd) != 0) begin
			line_no++;
			// Comments and blank lines
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
				col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15]);
			if (n != 16) begin
				$display("Trace line %0d could not be read, only %0d of 16 fields found",
					line_no, n);
				$fclose(fd);
				return;
			end
			row.rnd = col[0][0];
			row.req.valid = col[1][0];
			row.req.op = alu_opcode_e'(col[2][2:0]);
			row.req.a = col[3][15:0];
			row.req.b = col[4][15:0];
			row.bus.w = col[5][15:0];
			row.bus.w_zmvc = col[6][0];
			row.bus.w_legy = col[7][0];
			row.bus.w8_x = col[8][0];
			row.bus.w_user = col[9][0];
			row.cond_en = col[10][0];
			row.cond = col[11][3:0];
			row.exp_result = col[12][15:0];
			row.exp_r0 = col[13][15:0];
			row.exp_tv = col[14][0];
			row.exp_taken = col[15][0];
			rows.push_back(row);
			row_src_line.push_back(line_no);
		end
		$fclose(fd);
		if (rows.size() == 0) begin
			$display("Trace file %s holds no data lines", TRACE_PATH);
			return;
		end
		ok = 1'b1;
	endtask

	// Apply one line of stimulus on the current edge
	task automatic drive_row(input trace_row_t row);
		alu_req_t r;
		r = row.req;
		// Operands are don't-care on idle lines
		if (row.rnd) begin
			r.a = 16'($urandom);
			r.b = 16'($urandom);
		end
		req <= r;
		bus <= row.bus;
		cond_en <= row.cond_en;
		cond <= row.cond;
	endtask

	// Compare outputs with the expected columns of one line
	task automatic check_row(input int idx);
		trace_row_t row;
		int         src_line;
		row = rows[idx];
		src_line = row_src_line[idx];
		checks += 4;
		assert (result === row.exp_result) else begin
			$display("ERROR %0t: trace line %0d result is %h, expected %h",
				$time, src_line, result, row.exp_result);
			err_result++;
		end
		assert (r0 === row.exp_r0) else begin
			$display("ERROR %0t: trace line %0d r0 is %h, expected %h",
				$time, src_line, r0, row.exp_r0);
			err_r0++;
		end
		assert (taken_valid === row.exp_tv) else begin
			$display("ERROR %0t: trace line %0d taken_valid is %b, expected %b",
				$time, src_line, taken_valid, row.exp_tv);
			err_valid++;
		end
		assert (taken === row.exp_taken) else begin
			$display("ERROR %0t: trace line %0d taken is %b, expected %b",
				$time, src_line, taken, row.exp_taken);
			err_taken++;
		end
	endtask

	initial begin
		bit ok;
		int i;
		int total;
		void'($urandom(32'h4891));
		zer_ = 1'b0;
		req = '0;
		bus = '0;
		cond_en = 1'b0;
		cond = 4'd0;
		loaded = 1'b0;
		checks = 0;
		err_result = 0;
		err_r0 = 0;
		err_valid = 0;
		err_taken = 0;
		load_trace(ok);
		if (!ok) begin
			$display("Run stopped because the trace could not be used");
			$display("TEST FAILED");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (RESET_CYCLES) @(posedge lrp);
			zer_ <= 1'b1;
			// Line i is checked once the edge after its drive has passed
			for (i = 0; i < rows.size(); i++) begin
				@(posedge lrp);
				drive_row(rows[i]);
				@(negedge lrp);
				if (i > 0) begin
					check_row(i - 1);
				end
			end
			@(posedge lrp);
			drive_row('0);
			@(negedge lrp);
			check_row(rows.size() - 1);
			total = err_result + err_r0 + err_valid + err_taken;
			$display("%0d checks, %0d errors: result %0d, r0 %0d, taken_valid %0d, taken %0d",
				checks, total, err_result, err_r0, err_valid, err_taken);
			if (total == 0) begin
				$display("TEST PASSED");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

	// Watchdog sized from the trace length
	initial begin
		wait (loaded);
		#((rows.size() + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
		$display("Timeout: the run did not finish within its cycle budget");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/flags_trace.txt
# rnd valid op a b | w w_zmvc w_legy w8_x w_user | cond_en cond | result r0 taken_valid taken
# All hex, rnd=1 marks a and b as don't-care, expected values are after the edge taking the line
1 0 0 0000 0000 0000 0 0 0 0 0 0 0000 0000 0 0
1 0 0 0000 0000 0000 0 0 0 0 1 9 0000 0000 1 1
0 1 1 ffff 0001 0000 0 0 0 0 0 0 0000 0000 0 0
0 1 2 0005 0007 0000 0 0 0 0 0 0 fffe 9000 0 0
0 1 1 7fff 0001 0000 0 0 0 0 0 0 8000 4000 0 0
0 1 2 0009 0003 0000 0 0 0 0 0 0 0006 6000 0 0
1 0 0 0000 0000 0000 0 0 0 0 0 0 0006 3000 0 0
0 1 3 f0f0 0f0f 0000 0 0 0 0 0 0 0000 3000 0 0
0 1 4 8001 0100 0000 0 0 0 0 0 0 8101 a000 0 0
1 0 0 0000 0000 0000 0 0 0 0 0 0 8101 6000 0 0
0 1 5 8000 0001 0000 0 0 0 0 0 0 8101 6000 0 0
0 1 5 0005 0005 0000 0 0 0 0 0 0 8101 6800 0 0
0 1 5 0010 fff0 0000 0 0 0 0 0 0 8101 6400 0 0
0 1 6 c003 0000 0000 0 0 0 0 0 0 8006 6200 0 0
0 1 7 0005 0000 0000 0 0 0 0 0 0 0002 6300 0 0
0 1 6 4000 0000 0000 0 0 0 0 0 0 8000 6380 0 0
0 1 7 0004 0000 0000 0 0 0 0 0 0 0002 6280 0 0
1 0 0 0000 0000 0000 0 0 0 0 0 0 0002 6200 0 0
1 0 0 0000 0000 ffff 0 0 0 1 0 0 0002 627f 0 0
1 0 0 0000 0000 0000 1 0 0 0 0 0 0002 027f 0 0
1 0 0 0000 0000 a5a5 0 1 0 0 0 0 0002 057f 0 0
1 0 0 0000 0000 0080 0 0 1 0 0 0 0002 05ff 0 0
1 0 0 0000 0000 0000 0 0 0 1 0 0 0002 0580 0 0
0 1 1 7fff 7fff 0000 0 0 0 0 0 0 fffe 0580 0 0
1 0 0 0000 0000 1000 1 0 0 0 0 0 fffe 1580 0 0
0 1 5 0001 0002 0000 0 0 0 0 0 0 fffe 1580 0 0
1 0 0 0000 0000 0000 0 1 0 0 0 0 fffe 1080 0 0
0 1 7 0001 0000 0000 0 0 0 0 0 0 0000 1080 0 0
1 0 0 0000 0000 0000 0 0 1 0 0 0 0000 1000 0 0
1 0 0 0000 0000 0000 0 0 0 0 0 0 0000 1000 0 0
0 1 2 0000 0001 0000 0 0 0 0 0 0 ffff 1000 0 0
1 0 0 0000 0000 0e00 0 1 0 0 0 0 ffff 4e00 0 0
1 0 0 0000 0000 0000 0 0 0 0 1 0 ffff 4e00 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 1 ffff 4e00 1 1
1 0 0 0000 0000 0000 0 0 0 0 1 2 ffff 4e00 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 3 ffff 4e00 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 4 ffff 4e00 1 1
1 0 0 0000 0000 0000 0 0 0 0 1 5 ffff 4e00 1 1
1 0 0 0000 0000 0000 0 0 0 0 1 6 ffff 4e00 1 1
1 0 0 0000 0000 0000 0 0 0 0 1 7 ffff 4e00 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 8 ffff 4e00 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 9 ffff 4e00 1 1
1 0 0 0000 0000 0000 0 0 0 0 1 a ffff 4e00 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 b ffff 4e00 1 1
1 0 0 0000 0000 0000 0 0 0 0 1 c ffff 4e00 1 1
1 0 0 0000 0000 0000 0 0 0 0 1 d ffff 4e00 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 e ffff 4e00 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 f ffff 4e00 1 0
1 0 0 0000 0000 b180 1 1 1 0 0 0 ffff b180 0 0
1 0 0 0000 0000 0000 0 0 0 0 1 0 ffff b180 1 1
1 0 0 0000 0000 0000 0 0 0 0 1 9 ffff b180 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 8 ffff b180 1 1
1 0 0 0000 0000 0000 0 0 0 0 0 0 ffff b180 0 0
0 1 1 0001 0001 0000 0 0 0 0 0 0 0002 b180 0 0
0 1 5 0003 0001 0000 0 0 0 0 1 0 0002 2180 1 1
1 0 0 0000 0000 0000 0 0 0 0 1 6 0002 2380 1 0
1 0 0 0000 0000 0000 0 0 0 0 1 6 0002 2380 1 1
1 0 0 0000 0000 0000 0 0 0 0 0 0 0002 2380 0 0

//--- run.sh
#!/usr/bin/env bash
# Build and run the flag path testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module flags_tb -f sources.f -o Vflags_tb

./obj_dir/Vflags_tb | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi
echo "Simulation finished without failures"

//--- sources.f
verilog/flag_pkg.sv
verilog/alu_flags.sv
verilog/r0_register.sv
verilog/cond_test.sv
verilog/flags_top.sv
bench/flags_tb.sv

//--- verilog/alu_flags.sv
`default_nettype none

module alu_flags import flag_pkg::*; (
	input  logic        lrp,
	input  logic        zer_,
	input  alu_req_t    req,
	output logic [0:15] result,
	output flag_src_t   src
);

	// Operand b after inversion for subtract
	logic [0:15] b_op;
	// Carry into the adder, 1 for two's complement subtract
	logic        c_in;
	// Adder output, bit 0 holds the carry out
	logic [0:16] sum_ext;
	// Next result and next flag source
	logic [0:15] res_nxt;
	flag_src_t   src_nxt;

	// Shared adder for ADD and SUB
	always_comb begin
		b_op = (req.op == OP_SUB) ? ~req.b : req.b;
		c_in = (req.op == OP_SUB);
		sum_ext = {1'b0, req.a} + {1'b0, b_op} + {16'd0, c_in};
	end

	// Operation decode
	always_comb begin
		// CMP and NOP leave the stored result alone
		res_nxt = result;
		src_nxt = '0;
		case (req.op)
			OP_ADD, OP_SUB: begin
				res_nxt = sum_ext[1:16];
				// Carry out, on SUB this means no borrow
				src_nxt.carry = sum_ext[0];
				// Signed overflow when operand signs match but the sum sign differs
				src_nxt.ovf = (req.a[0] == b_op[0]) && (sum_ext[1] != req.a[0]);
				src_nxt.ust_zmc = 1'b1;
				src_nxt.ust_v = 1'b1;
			end
			OP_AND: begin
				res_nxt = req.a & req.b;
				src_nxt.ust_zmc = 1'b1;
			end
			OP_OR: begin
				res_nxt = req.a | req.b;
				src_nxt.ust_zmc = 1'b1;
			end
			OP_CMP: begin
				// Signed compare
				src_nxt.less = $signed(req.a) < $signed(req.b);
				src_nxt.equal = (req.a == req.b);
				src_nxt.greater = $signed(req.a) > $signed(req.b);
				src_nxt.ust_leg = 1'b1;
			end
			OP_SHL: begin
				// Bit 0 falls off the top into Y
				res_nxt = {req.a[1:15], 1'b0};
				src_nxt.y_out = req.a[0];
				src_nxt.ust_y = 1'b1;
			end
			OP_SHR: begin
				// Bit 15 falls off the bottom into X
				res_nxt = {1'b0, req.a[0:14]};
				src_nxt.x_out = req.a[15];
				src_nxt.ust_x = 1'b1;
			end
			default: begin
			end
		endcase
		// Zero and sign candidates follow the new result
		src_nxt.zs = (res_nxt == 16'd0);
		src_nxt.m = res_nxt[0];
	end

	// Output register, strobes last exactly one cycle
	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			result <= '0;
			src <= '0;
		end else if (req.valid) begin
			result <= res_nxt;
			src <= src_nxt;
		end else begin
			// Candidates hold, strobes drop
			src.ust_zmc <= 1'b0;
			src.ust_v <= 1'b0;
			src.ust_leg <= 1'b0;
			src.ust_y <= 1'b0;
			src.ust_x <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/cond_test.sv
`default_nettype none

module cond_test import flag_pkg::*; (
	input  logic       lrp,
	input  logic       zer_,
	input  r0_word_u   r0,
	input  logic       cond_en,
	input  logic [3:0] cond,
	output logic       taken,
	output logic       taken_valid
);

	// Flags gathered into an indexable vector
	logic [0:N_FLAGS-1] flag_v;
	// Condition outcome before registering
	logic               hit;

	always_comb begin
		flag_v[F_Z] = r0.f.z;
		flag_v[F_M] = r0.f.m;
		flag_v[F_V] = r0.f.v;
		flag_v[F_C] = r0.f.c;
		flag_v[F_L] = r0.f.l;
		flag_v[F_E] = r0.f.e;
		flag_v[F_G] = r0.f.g;
		flag_v[F_Y] = r0.f.y;
		flag_v[F_X] = r0.f.x;
	end

	// Codes 0..8 test a flag set
	// codes 9..15 test Z..G clear
	always_comb begin
		if (cond < 4'(N_FLAGS)) begin
			hit = flag_v[cond];
		end else begin
			hit = ~flag_v[cond - 4'(N_FLAGS)];
		end
	end

	// One-cycle result pulse, taken only meaningful with taken_valid
	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			taken_valid <= 1'b0;
			taken <= 1'b0;
		end else begin
			taken_valid <= cond_en;
			taken <= cond_en & hit;
		end
	end

endmodule

`default_nettype wire

//--- verilog/flag_pkg.sv
`default_nettype none

package flag_pkg;

	// Flag positions inside R0
	// Bit 0 is the most significant bit of the status word
	localparam int F_Z = 0;
	localparam int F_M = 1;
	localparam int F_V = 2;
	localparam int F_C = 3;
	localparam int F_L = 4;
	localparam int F_E = 5;
	localparam int F_G = 6;
	localparam int F_Y = 7;
	localparam int F_X = 8;

	// Number of testable flags, also the first inverted condition code
	localparam int N_FLAGS = 9;

	// User field spans the rest of the word
	localparam int F_USER = 9;
	localparam int R0_LSB = 15;

	// ALU operations
	typedef enum logic [2:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_CMP,
		OP_SHL,
		OP_SHR
	} alu_opcode_e;

	// Named view of R0, first field lands on bit 0
	typedef struct packed {
		logic       z;
		logic       m;
		logic       v;
		logic       c;
		logic       l;
		logic       e;
		logic       g;
		logic       y;
		logic       x;
		logic [0:6] user;
	} r0_flags_t;

	// Same 16-bit word seen raw (bus side) or as flags (condition side)
	typedef union packed {
		logic [0:15] raw;
		r0_flags_t   f;
	} r0_word_u;

	// One ALU request, taken whenever valid is high
	typedef struct packed {
		logic        valid;
		alu_opcode_e op;
		logic [0:15] a;
		logic [0:15] b;
	} alu_req_t;

	// Candidate flags plus the strobes saying which groups to update
	typedef struct packed {
		logic zs;
		logic m;
		logic ovf;
		logic carry;
		logic less;
		logic equal;
		logic greater;
		logic y_out;
		logic x_out;
		logic ust_zmc;
		logic ust_v;
		logic ust_leg;
		logic ust_y;
		logic ust_x;
	} flag_src_t;

	// W bus with its R0 load commands
	typedef struct packed {
		logic [0:15] w;
		logic        w_zmvc;
		logic        w_legy;
		logic        w8_x;
		logic        w_user;
	} bus_load_t;

endpackage

`default_nettype wire

//--- verilog/flags_top.sv
`default_nettype none

module flags_top import flag_pkg::*; (
	input  logic        lrp,
	input  logic        zer_,
	input  alu_req_t    req,
	input  bus_load_t   bus,
	input  logic        cond_en,
	input  logic [3:0]  cond,
	output logic [0:15] result,
	output logic [0:15] r0,
	output logic        taken,
	output logic        taken_valid
);

	// Candidate flags and strobes from the ALU
	flag_src_t src;
	// Status word as seen by the condition test
	r0_word_u  r0_w;

	// Producer
	alu_flags u_alu (
		.lrp    (lrp),
		.zer_   (zer_),
		.req    (req),
		.result (result),
		.src    (src)
	);

	// R0 status word
	r0_register u_r0 (
		.lrp  (lrp),
		.zer_ (zer_),
		.src  (src),
		.bus  (bus),
		.r0   (r0_w)
	);

	// Branch condition check
	cond_test u_cond (
		.lrp         (lrp),
		.zer_        (zer_),
		.r0          (r0_w),
		.cond_en     (cond_en),
		.cond        (cond),
		.taken       (taken),
		.taken_valid (taken_valid)
	);

	// Raw view out
	assign r0 = r0_w.raw;

endmodule

`default_nettype wire

//--- verilog/r0_register.sv
`default_nettype none

module r0_register import flag_pkg::*; (
	input  logic      lrp,
	input  logic      zer_,
	input  flag_src_t src,
	input  bus_load_t bus,
	output r0_word_u  r0
);

	// Status word R0
	// ALU strobes are applied first, bus commands after them
	// so the later assignment gives the bus priority per group
	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			// Reset is the only clear of V apart from a bus load
			r0.raw <= '0;
		end else begin
			// Z, M and C from add, subtract and logic ops
			if (src.ust_zmc) begin
				r0.f.z <= src.zs;
				r0.f.m <= src.m;
				r0.f.c <= src.carry;
			end

			// V only ever sets from the ALU
			// clearing it takes a bus load or reset
			if (src.ust_v && src.ovf) begin
				r0.f.v <= 1'b1;
			end

			// Compare results
			if (src.ust_leg) begin
				r0.f.l <= src.less;
				r0.f.e <= src.equal;
				r0.f.g <= src.greater;
			end

			// Shift-out bits
			if (src.ust_y) begin
				r0.f.y <= src.y_out;
			end
			if (src.ust_x) begin
				r0.f.x <= src.x_out;
			end

			// Bus writes of Z, M, V, C
			if (bus.w_zmvc) begin
				r0.raw[F_Z:F_C] <= bus.w[F_Z:F_C];
			end

			// Bus writes of L, E, G, Y
			if (bus.w_legy) begin
				r0.raw[F_L:F_Y] <= bus.w[F_L:F_Y];
			end

			// Bus write of X alone
			if (bus.w8_x) begin
				r0.raw[F_X] <= bus.w[F_X];
			end

			// User bits stored as written
			if (bus.w_user) begin
				r0.raw[F_USER:R0_LSB] <= bus.w[F_USER:R0_LSB];
			end
		end
	end

endmodule

`default_nettype wire
